/* cache_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_controller
	import cache_pkg::*;
(
	input  wire   clk,
	input  wire   rst_n,
	input  wire   op,
	input  wire   write,
	input  addr_t address,
	input  word_t data_in,
	output word_t data_out,
	output logic  stall,
	output logic  miss_detected,
	input  wire   service,
	output addr_t addr_to_mem,
	input  wire   data_valid,
	input  word_t data_from_mem
);

	// address fields
	tag_t    req_tag;
	index_t  req_index;
	offset_t req_offset;

	// lookup result
	logic line_valid;
	tag_t stored_tag;

	// fill FSM outputs
	logic    fsm_busy;
	logic    data_write;
	logic    tag_write;
	addr_t   addr_fsm;
	offset_t offset_fsm;
	logic    cnt_clear;
	logic    cnt_issue;
	logic    cnt_ret;

	// word counter outputs
	fill_count_t issued_count;
	fill_count_t returned_count;
	logic        issue_done;
	logic        fill_done;

	// data array port
	offset_t array_offset;
	word_t   array_wdata;
	logic    array_write;
	logic    write_hit;

	// bit 0 is the byte select and is ignored
	assign req_tag    = address[15 -: TAG_W];
	assign req_index  = address[OFFSET_W+1 +: INDEX_W];
	assign req_offset = address[1 +: OFFSET_W];

	// miss when the line is empty or holds another block
	assign miss_detected = op && (!line_valid || (req_tag != stored_tag));
	assign stall = fsm_busy || miss_detected;

	// during a fill the FSM owns the address, offset and write data
	assign addr_to_mem  = fsm_busy ? addr_fsm : address;
	assign array_offset = fsm_busy ? offset_fsm : req_offset;
	assign array_wdata  = fsm_busy ? data_from_mem : data_in;

	// write hits stay in the cache, memory is not updated
	assign write_hit   = op && write && !stall;
	assign array_write = data_write || write_hit;

	cache_fill_fsm u_fsm (
		.clk               (clk),
		.rst_n             (rst_n),
		.miss_address      (address),
		.miss_detected     (miss_detected),
		.service           (service),
		.memory_data_valid (data_valid),
		.issue_done        (issue_done),
		.fill_done         (fill_done),
		.returned_count    (returned_count),
		.fsm_busy          (fsm_busy),
		.memory_address    (addr_fsm),
		.offset            (offset_fsm),
		.write_data_array  (data_write),
		.write_tag_array   (tag_write),
		.counter_clear     (cnt_clear),
		.counter_issue     (cnt_issue),
		.counter_ret       (cnt_ret)
	);

	fill_word_counter u_counter (
		.clk            (clk),
		.rst_n          (rst_n),
		.clear          (cnt_clear),
		.issue          (cnt_issue),
		.ret            (cnt_ret),
		.issued_count   (issued_count),
		.returned_count (returned_count),
		.issue_done     (issue_done),
		.fill_done      (fill_done)
	);

	data_array u_data (
		.clk      (clk),
		.rst_n    (rst_n),
		.data_in  (array_wdata),
		.write    (array_write),
		.index    (req_index),
		.offset   (array_offset),
		.data_out (data_out)
	);

	tag_array u_tags (
		.clk     (clk),
		.rst_n   (rst_n),
		.write   (tag_write),
		.index   (req_index),
		.tag_in  (req_tag),
		.valid   (line_valid),
		.tag_out (stored_tag)
	);

	// the last word cannot come back before every request went out
	a_fill_issued: assert property (@(posedge clk) disable iff (!rst_n)
		tag_write |-> (issued_count == fill_count_t'(WORDS_PER_BLOCK)));

	// once the tag is written the held request hits
	a_fill_hits: assert property (@(posedge clk) disable iff (!rst_n)
		tag_write |=> line_valid && (stored_tag == req_tag));

endmodule

`default_nettype wire

/* cache_fill_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_fill_fsm
	import cache_pkg::*;
(
	input  wire         clk,
	input  wire         rst_n,
	input  addr_t       miss_address,
	input  wire         miss_detected,
	input  wire         service,
	input  wire         memory_data_valid,
	input  wire         issue_done,
	input  wire         fill_done,
	input  fill_count_t returned_count,
	output logic        fsm_busy,
	output addr_t       memory_address,
	output offset_t     offset,
	output logic        write_data_array,
	output logic        write_tag_array,
	output logic        counter_clear,
	output logic        counter_issue,
	output logic        counter_ret
);

	fill_state_t state;
	fill_state_t state_next;
	// word number of the next request to memory
	offset_t issue_word;

	// state register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= idle;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			idle:       if (miss_detected) state_next = wait_grant;
			// arbiter may hold off the grant for a while
			wait_grant: if (service) state_next = filling;
			filling:    if (fill_done) state_next = finish;
			// tag is written, give the lookup one cycle to see it
			finish:     state_next = idle;
			default:    state_next = idle;
		endcase
	end

	// request pointer, walks offset 0..7
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			issue_word <= '0;
		else if (state == idle)
			issue_word <= '0;
		else if (counter_issue)
			issue_word <= issue_word + 1'b1;
	end

	assign fsm_busy = (state != idle);

	// counters restart for every fill
	assign counter_clear = (state == idle);
	assign counter_issue = (state == filling) && !issue_done;
	assign counter_ret   = (state == filling) && memory_data_valid;

	// tag and index come from the held miss address
	assign memory_address = {miss_address[15:OFFSET_W+1], issue_word, 1'b0};

	// returns are in order, so the return count picks the slot
	assign offset = returned_count[OFFSET_W-1:0];

	assign write_data_array = counter_ret;
	// line becomes valid together with its last word
	assign write_tag_array  = (state == filling) && fill_done;

	// every returned word lands in the array and nothing else does
	a_wr_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
		write_data_array == memory_data_valid);

endmodule

`default_nettype wire

/* cache_pkg.sv */
`default_nettype none

package cache_pkg;

	// cache geometry, 2 KB direct mapped
	localparam int NUM_LINES       = 128;
	localparam int WORDS_PER_BLOCK = 8;

	// address split: tag | index | offset | unused byte bit
	localparam int TAG_W    = 5;
	localparam int INDEX_W  = 7;
	localparam int OFFSET_W = 3;

	// byte address from the processor
	typedef logic [15:0] addr_t;

	// one 16-bit data word
	typedef logic [15:0] word_t;

	// address bits 15..11
	typedef logic [TAG_W-1:0] tag_t;

	// address bits 10..4
	typedef logic [INDEX_W-1:0] index_t;

	// address bits 3..1, word inside a block
	typedef logic [OFFSET_W-1:0] offset_t;

	// holds 0 up to a full block of words
	typedef logic [$clog2(WORDS_PER_BLOCK+1)-1:0] fill_count_t;

	// block fill sequence
	typedef enum logic [1:0] {
		idle,
		wait_grant,
		filling,
		finish
	} fill_state_t;

endpackage

`default_nettype wire

/* cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tb
	import cache_pkg::*;
();

	localparam int MEM_LATENCY  = 4;
	localparam int SEED         = 32'hcd96_d516;
	localparam int NUM_RANDOM   = 300;
	localparam int NUM_DIRECTED = 28;
	// entry, grant delay, 8 issues, latency, finish and slack
	localparam int FILL_CYCLES  = 4 + WORDS_PER_BLOCK + MEM_LATENCY + 4;
	localparam int TIMEOUT_NS   = 2 * (NUM_DIRECTED + NUM_RANDOM) * FILL_CYCLES * 8;

	logic  clk;
	logic  rst_n;
	logic  op;
	logic  write;
	addr_t address;
	word_t data_in;
	word_t data_out;
	logic  stall;
	logic  miss_detected;
	logic  service = 1'b0;
	addr_t addr_to_mem;
	logic  data_valid = 1'b0;
	word_t data_from_mem = '0;

	// shadow copy of the cache contents
	logic  shadow_valid [NUM_LINES];
	tag_t  shadow_tag [NUM_LINES];
	word_t shadow_words [NUM_LINES][WORDS_PER_BLOCK];

	// outstanding memory requests, oldest first
	addr_t pend_addr [$];
	int    pend_due [$];

	int mismatch_count = 0;
	int check_count = 0;
	int completed = 0;
	int seed_dummy;
	int cycle = 0;
	int fill_idx = 0;
	int grant_delay = 0;
	logic granted = 1'b0;
	logic busy_q = 1'b0;
	logic req_open = 1'b0;

	tb_clock_gen clock_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	cache_controller UUT (
		.clk           (clk),
		.rst_n         (rst_n),
		.op            (op),
		.write         (write),
		.address       (address),
		.data_in       (data_in),
		.data_out      (data_out),
		.stall         (stall),
		.miss_detected (miss_detected),
		.service       (service),
		.addr_to_mem   (addr_to_mem),
		.data_valid    (data_valid),
		.data_from_mem (data_from_mem)
	);

	// memory contents: address rotated left by 5, then xor
	function automatic word_t mem_word(input addr_t a);
		return {a[10:0], a[15:11]} ^ 16'h5a3c;
	endfunction

	function automatic logic predict_miss(input addr_t a);
		return !shadow_valid[a[10:4]] || (shadow_tag[a[10:4]] != a[15:11]);
	endfunction

	// reference for a completed read
	function automatic word_t expected_read(input addr_t a);
		return shadow_words[a[10:4]][a[3:1]];
	endfunction

	function automatic addr_t block_word(input addr_t base, input int w);
		return {base[15:4], w[2:0], 1'b0};
	endfunction

	task automatic check_value(input string name, input word_t got, input word_t exp);
		check_count++;
		if (got !== exp) begin
			mismatch_count++;
			$display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// a miss replaces the whole line with memory contents
	task automatic fill_shadow(input addr_t a);
		int w;
		shadow_valid[a[10:4]] = 1'b1;
		shadow_tag[a[10:4]] = a[15:11];
		for (w = 0; w < WORDS_PER_BLOCK; w++)
			shadow_words[a[10:4]][w] = mem_word(block_word(a, w));
	endtask

	// arbiter and memory, sampled on the rising edge
	always @(posedge clk) begin
		cycle++;
		if (!rst_n) begin
			service <= 1'b0;
			data_valid <= 1'b0;
		end else begin
			data_valid <= 1'b0;
			// each issue cycle is one request, checked against the missing block
			if (UUT.cnt_issue) begin
				check_value("addr_to_mem", addr_to_mem, block_word(address, fill_idx));
				pend_addr.push_back(addr_to_mem);
				pend_due.push_back(cycle + MEM_LATENCY);
				fill_idx++;
			end
			if (pend_due.size() > 0 && pend_due[0] == cycle) begin
				data_valid <= 1'b1;
				data_from_mem <= mem_word(pend_addr.pop_front());
				void'(pend_due.pop_front());
			end
			// one cycle grant after a random wait
			if (service)
				service <= 1'b0;
			else if (UUT.fsm_busy && !granted) begin
				if (grant_delay == 0) begin
					service <= 1'b1;
					granted = 1'b1;
				end else
					grant_delay--;
			end
			if (!UUT.fsm_busy) begin
				// a finished fill must have asked for exactly one block
				if (busy_q)
					check_value("fill words", 16'(fill_idx), 16'(WORDS_PER_BLOCK));
				granted = 1'b0;
				fill_idx = 0;
				grant_delay = $urandom % 4;
			end
			busy_q = UUT.fsm_busy;
		end
	end

	// compare on the falling edge, where outputs are settled
	always @(negedge clk) begin
		int i;
		if (!rst_n) begin
			for (i = 0; i < NUM_LINES; i++)
				shadow_valid[i] = 1'b0;
			req_open = 1'b0;
		end else if (!op) begin
			check_value("stall", 16'(stall), 16'h0);
			check_value("miss_detected", 16'(miss_detected), 16'h0);
			req_open = 1'b0;
		end else begin
			// first cycle of a request shows hit or miss at once
			if (!req_open) begin
				check_value("stall", 16'(stall), 16'(predict_miss(address)));
				check_value("miss_detected", 16'(miss_detected), 16'(predict_miss(address)));
			end
			req_open = 1'b1;
			if (!stall) begin
				if (predict_miss(address))
					fill_shadow(address);
				if (write)
					shadow_words[address[10:4]][address[3:1]] = data_in;
				else
					check_value("data_out", data_out, expected_read(address));
				req_open = 1'b0;
				completed++;
			end
		end
	end

	// hold the request until the cycle it completes
	task automatic issue_request(input logic wr, input addr_t a, input word_t d);
		@(posedge clk);
		op <= 1'b1;
		write <= wr;
		address <= a;
		data_in <= d;
		@(negedge clk);
		while (stall)
			@(negedge clk);
	endtask

	task automatic read_block(input addr_t base);
		int w;
		for (w = 0; w < WORDS_PER_BLOCK; w++)
			issue_request(1'b0, block_word(base, w), 16'h0000);
	endtask

	task automatic go_idle(input int cycles);
		@(posedge clk);
		op <= 1'b0;
		write <= 1'b0;
		repeat (cycles) @(posedge clk);
	endtask

	task automatic random_run(input int count);
		int n;
		addr_t a;
		logic wr;
		for (n = 0; n < count; n++) begin
			// few tags and lines so hits, misses and evictions all occur
			a = {3'b000, 2'($urandom % 4), 4'b0000, 3'($urandom % 8),
				3'($urandom % 8), 1'($urandom % 2)};
			wr = ($urandom % 10) < 4;
			issue_request(wr, a, 16'($urandom));
		end
	endtask

	initial begin
		seed_dummy = $urandom(SEED);
		op = 1'b0;
		write = 1'b0;
		address = '0;
		data_in = '0;
		wait (rst_n === 1'b1);
		go_idle(4);
		// cold miss, then every word of the block hits
		issue_request(1'b0, 16'h1234, 16'h0000);
		read_block(16'h1234);
		// write hit leaves the neighbours alone
		issue_request(1'b1, 16'h1236, 16'hbeef);
		read_block(16'h1230);
		// same index, other tag evicts the line
		issue_request(1'b0, 16'h1a34, 16'h0000);
		read_block(16'h1a30);
		// old block comes back from memory, write is gone
		issue_request(1'b0, 16'h1236, 16'h0000);
		go_idle(3);
		random_run(NUM_RANDOM);
		go_idle(3);
		$display("requests %0d, checks %0d, mismatches %0d", completed, check_count,
			mismatch_count);
		if (mismatch_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// run limit
	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired after %0d ns, a request never completed", TIMEOUT_NS);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* data_array.sv */
`timescale 1ns/1ps
`default_nettype none

module data_array
	import cache_pkg::*;
(
	input  wire     clk,
	input  wire     rst_n,
	input  word_t   data_in,
	input  wire     write,
	input  index_t  index,
	input  offset_t offset,
	output word_t   data_out
);

	// line x word storage
	word_t lines [NUM_LINES][WORDS_PER_BLOCK];

	// one word per write, selected by line and offset
	// no stores while reset is applied
	always_ff @(posedge clk) begin
		if (write && rst_n)
			lines[index][offset] <= data_in;
	end

	// read path is combinational so a hit returns in its own cycle
	assign data_out = lines[index][offset];

endmodule

`default_nettype wire

/* files.f */
cache_pkg.sv
fill_word_counter.sv
cache_fill_fsm.sv
data_array.sv
tag_array.sv
cache_controller.sv
tb_clock_gen.sv
cache_tb.sv

/* fill_word_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module fill_word_counter
	import cache_pkg::*;
(
	input  wire         clk,
	input  wire         rst_n,
	input  wire         clear,
	input  wire         issue,
	input  wire         ret,
	output fill_count_t issued_count,
	output fill_count_t returned_count,
	output logic        issue_done,
	output logic        fill_done
);

	localparam fill_count_t FULL = fill_count_t'(WORDS_PER_BLOCK);

	// all requests of the block are out
	assign issue_done = (issued_count == FULL);
	// last word is on the bus this cycle
	assign fill_done = ret && (returned_count == FULL - 1'b1);

	// both counters saturate at a full block
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			issued_count   <= '0;
			returned_count <= '0;
		end else if (clear) begin
			issued_count   <= '0;
			returned_count <= '0;
		end else begin
			if (issue && !issue_done)
				issued_count <= issued_count + 1'b1;
			if (ret && returned_count != FULL)
				returned_count <= returned_count + 1'b1;
		end
	end

	// memory can only answer what was asked
	a_ret_le_issue: assert property (@(posedge clk) disable iff (!rst_n)
		returned_count <= issued_count);

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --assert --top-module cache_tb -f files.f -o cache_sim > build.log 2>&1 \
	&& ./obj_dir/cache_sim > sim.log 2>&1 \
	|| { echo "build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "=== FAIL ===" sim.log \
	&& { echo "simulation failed"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }

/* tag_array.sv */
`timescale 1ns/1ps
`default_nettype none

module tag_array
	import cache_pkg::*;
(
	input  wire    clk,
	input  wire    rst_n,
	input  wire    write,
	input  index_t index,
	input  tag_t   tag_in,
	output logic   valid,
	output tag_t   tag_out
);

	// one valid flag per line
	logic [NUM_LINES-1:0] valid_bits;
	tag_t tags [NUM_LINES];

	// reset invalidates the whole cache
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			valid_bits <= '0;
		else if (write)
			valid_bits[index] <= 1'b1;
	end

	// tag per line, loaded when a fill completes
	always_ff @(posedge clk) begin
		if (write)
			tags[index] <= tag_in;
	end

	assign valid   = valid_bits[index];
	assign tag_out = tags[index];

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	// 8 ns period, 4 ns per phase
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// reset low over the first three rising edges
	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire
